// ==== tb.f ====
+incdir+tests
src/exePkg.sv
src/exeBus.sv
src/alu.sv
src/mulDiv.sv
src/operandStage.sv
src/computeStage.sv
src/dataMem.sv
src/writebackStage.sv
src/exeTop.sv
tests/exeTb.sv

// ==== tests/exeModel.svh ====
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

// one issued instruction as seen at the top ports
typedef struct packed {
	logic [31:0] opA, opB, pc, bImm, jImm, uImm;
	logic [31:0] csrImm, csrData, memOffset;
	logic [11:0] csrAddr;
	exePkg::aluOp alu;
	exePkg::mulOp mul;
	exePkg::csrOp csr;
	exePkg::memOp mem;
	exePkg::wbSel sel;
	logic branch, branchNe, jump, jumpReg;
	logic [4:0] rd;
	logic we, instrMis, ecall;
} issueRec;

// expected outputs, stamped with the issue cycle
typedef struct packed {
	int stamp;
	logic bjTaken;
	logic [31:0] target;
	logic [31:0] wbData;
	logic we;
	logic [4:0] rd;
	logic [31:0] csrWb;
	logic [11:0] csrWbAddr;
	logic excPending;
	logic [31:0] mCause;
} expRec;

logic [31:0] shadow [memWords];

function automatic logic [31:0] aluRef(exePkg::aluOp op, logic [31:0] a, logic [31:0] b);
	int sa;
	int sb;
	logic [63:0] ext;
	sa = a;
	sb = b;
	ext = {{32{a[31]}}, a};  // sign-filled for sra
	case (op)
		exePkg::aluAdd: return a + b;
		exePkg::aluSub: return a + ~b + 32'd1;
		exePkg::aluSll: return a << (b % 32);
		exePkg::aluSlt: return (sa < sb) ? 32'd1 : 32'd0;
		exePkg::aluSltu: return (a < b) ? 32'd1 : 32'd0;
		exePkg::aluXor: return a ^ b;
		exePkg::aluSrl: return a >> (b % 32);
		exePkg::aluSra: return 32'(ext >> (b % 32));
		exePkg::aluOr: return a | b;
		exePkg::aluAnd: return a & b;
		default: return 32'd0;
	endcase
endfunction

function automatic logic [31:0] mulDivRef(exePkg::mulOp op, logic [31:0] a, logic [31:0] b);
	longint sa;
	longint sb;
	longint unsigned ua;
	longint unsigned ub;
	logic [63:0] res;
	sa = $signed(a);
	sb = $signed(b);
	ua = a;
	ub = b;
	case (op)
		exePkg::mdMul: res = sa * sb;
		exePkg::mdMulh: res = (sa * sb) >> 32;
		exePkg::mdMulhsu: res = (sa * ub) >> 32;  // low 64 bits exact either way
		exePkg::mdMulhu: res = (ua * ub) >> 32;
		exePkg::mdDiv:
			if (b == 32'd0)
				res = '1;
			else
				res = sa / sb;  // -2^31 / -1 is 2^31 here, low word is the dividend
		exePkg::mdDivu:
			if (b == 32'd0)
				res = '1;
			else
				res = ua / ub;
		exePkg::mdRem:
			if (b == 32'd0)
				res = {32'b0, a};
			else
				res = sa % sb;
		default:
			if (b == 32'd0)
				res = {32'b0, a};
			else
				res = ua % ub;
	endcase
	return res[31:0];
endfunction

function automatic logic misalignedRef(exePkg::memOp op, logic [31:0] addr);
	case (op)
		exePkg::memLh, exePkg::memLhu, exePkg::memSh: return addr[0];
		exePkg::memLw, exePkg::memSw: return addr[1:0] != 2'b00;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] loadRef(exePkg::memOp op, logic [31:0] word, logic [1:0] off);
	logic [7:0] b8;
	logic [15:0] h16;
	b8 = 8'(word >> (8 * off));
	h16 = 16'(word >> (8 * off));
	case (op)
		exePkg::memLb: return {{24{b8[7]}}, b8};
		exePkg::memLbu: return {24'b0, b8};
		exePkg::memLh: return {{16{h16[15]}}, h16};
		exePkg::memLhu: return {16'b0, h16};
		default: return word;
	endcase
endfunction

function automatic expRec predict(issueRec r);
	expRec e;
	logic [31:0] addr;
	logic [31:0] src;
	logic cond;
	logic misLd;
	logic misSt;
	e = '0;
	addr = r.opA + r.memOffset;
	misLd = (r.mem inside {exePkg::memLh, exePkg::memLw, exePkg::memLhu}) &&
		misalignedRef(r.mem, addr);
	misSt = (r.mem inside {exePkg::memSh, exePkg::memSw}) && misalignedRef(r.mem, addr);

	if (r.jumpReg)
	begin
		e.target = r.opA + r.opB;
		e.target[0] = 1'b0;
	end
	else
		e.target = r.jump ? r.pc + r.jImm : r.pc + r.bImm;
	case (r.alu)
		exePkg::aluSub: cond = (r.opA == r.opB);
		exePkg::aluSlt: cond = ($signed(r.opA) < $signed(r.opB));
		exePkg::aluSltu: cond = (r.opA < r.opB);
		default: cond = 1'b0;
	endcase
	e.bjTaken = r.jump || r.jumpReg || (r.branch && (cond != r.branchNe));

	src = (r.csr inside {exePkg::csrRwi, exePkg::csrRsi, exePkg::csrRci}) ? r.csrImm : r.opA;
	case (r.csr)
		exePkg::csrRw, exePkg::csrRwi: e.csrWb = src;
		exePkg::csrRs, exePkg::csrRsi: e.csrWb = r.csrData | src;
		exePkg::csrRc, exePkg::csrRci: e.csrWb = r.csrData & ~src;
		default: e.csrWb = r.csrData;
	endcase
	e.csrWbAddr = r.csrAddr;

	case (r.sel)
		exePkg::wbAlu: e.wbData = aluRef(r.alu, r.opA, r.opB);
		exePkg::wbPcLink: e.wbData = r.pc + 32'd4;
		exePkg::wbMulDiv: e.wbData = mulDivRef(r.mul, r.opA, r.opB);
		exePkg::wbLui: e.wbData = r.uImm;
		exePkg::wbLoad: e.wbData = loadRef(r.mem, shadow[addr[31:2] % memWords], addr[1:0]);
		exePkg::wbAuipc: e.wbData = r.pc + r.uImm;
		default: e.wbData = r.csrData;  // old CSR value
	endcase

	e.excPending = r.instrMis || r.ecall || misLd || misSt;
	if (r.instrMis)
		e.mCause = 32'd0;
	else if (r.ecall)
		e.mCause = 32'd11;
	else if (misLd)
		e.mCause = 32'd4;
	else
		e.mCause = 32'd6;
	e.we = r.we && !e.excPending;
	e.rd = r.rd;
	return e;
endfunction

// shadow write, misaligned stores leave memory alone
function automatic void storeRef(issueRec r);
	logic [31:0] addr;
	int idx;
	addr = r.opA + r.memOffset;
	idx = addr[31:2] % memWords;
	if (misalignedRef(r.mem, addr))
		return;
	case (r.mem)
		exePkg::memSb: shadow[idx][8 * addr[1:0] +: 8] = r.opB[7:0];
		exePkg::memSh: shadow[idx][8 * addr[1:0] +: 16] = r.opB[15:0];
		exePkg::memSw: shadow[idx] = r.opB;
		default: ;
	endcase
endfunction

`endif

// ==== tests/exeTb.sv ====
`default_nettype none

module exeTb;

	localparam int memWords = 256;
	localparam int period = 8;
	localparam int nAlu = 60;
	localparam int nBr = 40;
	localparam int nMd = 60;
	localparam int nMem = 60;
	localparam int nCsr = 30;
	localparam int nExc = 40;
	// memory and exception loops can issue two each
	localparam int maxIssues = memWords + nAlu + nBr + nMd + 2 * nMem + nCsr + 2 * nExc;

	`include "exeModel.svh"

	logic clk;
	logic nrst;
	logic [31:0] opA, opB, pc, bImm, jImm, uImm;
	exePkg::aluOp aluOp;
	exePkg::mulOp mulOp;
	exePkg::csrOp csrOp;
	logic [31:0] csrImm, csrData;
	logic [11:0] csrAddr;
	logic branch, branchNe, jump, jumpReg;
	exePkg::wbSel wbSel;
	logic [4:0] rd;
	logic we, instrMisaligned, ecall;
	exePkg::memOp memOp;
	logic [31:0] memOffset;
	logic bjTaken;
	logic [31:0] target;
	logic [31:0] wbData;
	logic wbWe;
	logic [4:0] wbRd;
	logic [31:0] csrWb;
	logic [11:0] csrWbAddr;
	logic excPending;
	logic [31:0] mCause;

	integer seed = 32'ha652a5ec;
	int cycleNo = 0;
	int errors = 0;
	int checks = 0;
	expRec bjQ[$];  // checked one cycle after issue
	expRec wbQ[$];  // checked two cycles after issue

	exeTop #(.memWords(memWords)) dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycleNo <= cycleNo + 1;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic int unsigned below(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// corner values now and then
	function automatic logic [31:0] operand();
		case (below(8))
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			default: return rand32();
		endcase
	endfunction

	function automatic issueRec nop();
		issueRec r;
		r = '0;
		return r;
	endfunction

	function automatic logic [31:0] fillWord(int i);
		return (i * 32'h9e37_79b9) ^ {i[15:0], 16'h5a3c};
	endfunction

	function automatic logic [31:0] alignedAddr(exePkg::memOp op);
		logic [31:0] a;
		a = below(32) * 4;
		case (op)
			exePkg::memSb, exePkg::memLb, exePkg::memLbu: a += below(4);
			exePkg::memSh, exePkg::memLh, exePkg::memLhu: a += 2 * below(2);
			default: ;
		endcase
		if (below(4) == 0)
			a += memWords * 4 * (1 + below(3));  // wraps onto the same word
		return a;
	endfunction

	function automatic exePkg::memOp loadOf(exePkg::memOp op);
		case (op)
			exePkg::memSb: return below(2) ? exePkg::memLb : exePkg::memLbu;
			exePkg::memSh: return below(2) ? exePkg::memLh : exePkg::memLhu;
			default: return exePkg::memLw;
		endcase
	endfunction

	// random base/offset split of one address
	function automatic issueRec accessAt(exePkg::memOp op, logic [31:0] addr);
		issueRec r;
		logic [31:0] x;
		r = nop();
		x = rand32();
		r.mem = op;
		r.memOffset = {{24{x[7]}}, x[7:0]};
		r.opA = addr - r.memOffset;
		r.opB = rand32();
		r.rd = 5'(rand32());
		if (op inside {exePkg::memLb, exePkg::memLh, exePkg::memLw, exePkg::memLbu,
			exePkg::memLhu})
		begin
			r.sel = exePkg::wbLoad;
			r.we = 1'b1;
		end
		return r;
	endfunction

	task automatic applyIssue(issueRec r);
		opA = r.opA;
		opB = r.opB;
		pc = r.pc;
		bImm = r.bImm;
		jImm = r.jImm;
		uImm = r.uImm;
		aluOp = r.alu;
		mulOp = r.mul;
		csrOp = r.csr;
		csrImm = r.csrImm;
		csrData = r.csrData;
		csrAddr = r.csrAddr;
		branch = r.branch;
		branchNe = r.branchNe;
		jump = r.jump;
		jumpReg = r.jumpReg;
		wbSel = r.sel;
		rd = r.rd;
		we = r.we;
		instrMisaligned = r.instrMis;
		ecall = r.ecall;
		memOp = r.mem;
		memOffset = r.memOffset;
	endtask

	// drive on the falling edge and queue what should come out
	task automatic issue(issueRec r);
		expRec e;
		@(negedge clk);
		applyIssue(r);
		e = predict(r);
		storeRef(r);
		e.stamp = cycleNo;
		bjQ.push_back(e);
		wbQ.push_back(e);
	endtask

	initial
	begin
		issueRec r;
		logic [31:0] x;
		logic [31:0] addr;
		exePkg::memOp mop;
		// busy inputs while reset holds the pipeline
		r = nop();
		r.we = 1'b1;
		r.jump = 1'b1;
		r.ecall = 1'b1;
		r.mem = exePkg::memLw;
		r.memOffset = 32'd1;  // misaligned load
		applyIssue(r);
		nrst = 1'b0;
		repeat (5) @(negedge clk);
		assert (wbWe === 1'b0 && bjTaken === 1'b0 && excPending === 1'b0)
		else
		begin
			errors++;
			$display("ERROR %0t: outputs active during reset", $time);
		end
		applyIssue(nop());
		nrst = 1'b1;

		for (int i = 0; i < memWords; i++)
		begin
			r = accessAt(exePkg::memSw, i * 4);
			r.opB = fillWord(i);
			issue(r);
		end

		for (int i = 0; i < nAlu; i++)
		begin
			r = nop();
			r.alu = exePkg::aluOp'(below(10));
			r.opA = operand();
			r.opB = operand();
			r.pc = rand32() & ~32'd3;
			r.uImm = rand32() & 32'hffff_f000;
			case (below(6))
				0: r.sel = exePkg::wbLui;
				1: r.sel = exePkg::wbAuipc;
				default: r.sel = exePkg::wbAlu;
			endcase
			r.we = 1'b1;
			r.rd = 5'(rand32());
			issue(r);
		end

		for (int i = 0; i < nBr; i++)
		begin
			r = nop();
			r.pc = rand32() & ~32'd3;
			r.opA = operand();
			r.opB = below(2) ? r.opA : operand();
			x = rand32();
			r.bImm = {{19{x[12]}}, x[12:1], 1'b0};
			r.jImm = {{11{x[20]}}, x[20:1], 1'b0};
			r.rd = 5'(rand32());
			case (below(3))
				0:
				begin
					r.branch = 1'b1;
					r.branchNe = 1'(below(2));
					case (below(3))
						0: r.alu = exePkg::aluSub;
						1: r.alu = exePkg::aluSlt;
						default: r.alu = exePkg::aluSltu;
					endcase
				end
				1:
				begin
					r.jump = 1'b1;
					r.sel = exePkg::wbPcLink;
					r.we = 1'b1;
				end
				default:
				begin
					r.jumpReg = 1'b1;
					r.opB = {{20{x[11]}}, x[11:0]};
					r.sel = exePkg::wbPcLink;
					r.we = 1'b1;
				end
			endcase
			issue(r);
		end

		for (int i = 0; i < nMd; i++)
		begin
			r = nop();
			r.mul = exePkg::mulOp'(below(8));
			r.opA = operand();
			r.opB = (below(6) == 0) ? 32'd0 : operand();
			if (below(8) == 0)
			begin
				r.opA = 32'h8000_0000;  // signed overflow pair
				r.opB = 32'hffff_ffff;
			end
			r.sel = exePkg::wbMulDiv;
			r.we = 1'b1;
			r.rd = 5'(rand32());
			issue(r);
		end

		for (int i = 0; i < nMem; i++)
		begin
			case (below(3))
				0: mop = exePkg::memSb;
				1: mop = exePkg::memSh;
				default: mop = exePkg::memSw;
			endcase
			addr = alignedAddr(mop);
			if (below(3) == 0)
				issue(accessAt(loadOf(mop), addr));
			else
			begin
				issue(accessAt(mop, addr));
				if (below(2) == 0)
					issue(accessAt(loadOf(mop), addr));  // back to back on the same word
			end
		end

		for (int i = 0; i < nCsr; i++)
		begin
			r = nop();
			r.csr = exePkg::csrOp'(below(7));
			r.csrData = rand32();
			r.opA = rand32();
			r.csrImm = below(32);  // 5-bit zimm
			r.csrAddr = 12'(rand32());
			r.sel = exePkg::wbCsr;
			r.we = 1'b1;
			r.rd = 5'(rand32());
			issue(r);
		end

		for (int i = 0; i < nExc; i++)
		begin
			case (below(5))
				0: mop = exePkg::memNone;
				1: mop = exePkg::memLh;
				2: mop = exePkg::memLw;
				3: mop = exePkg::memSh;
				default: mop = exePkg::memSw;
			endcase
			addr = below(32) * 4 + below(4);
			r = accessAt(mop, addr);
			r.we = 1'b1;
			r.instrMis = (below(3) == 0);
			r.ecall = (below(3) == 0);
			issue(r);
			// read the word back to see a bad store left it alone
			if (mop inside {exePkg::memSh, exePkg::memSw} && misalignedRef(mop, addr) &&
				below(2) == 0)
				issue(accessAt(exePkg::memLw, {addr[31:2], 2'b00}));
		end

		repeat (3)
		begin
			@(negedge clk);
			applyIssue(nop());
		end
		@(posedge clk);
		assert (bjQ.size() == 0 && wbQ.size() == 0)
		else
		begin
			errors++;
			$display("some expected results were never compared (%0d, %0d left)",
				bjQ.size(), wbQ.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// results are stable on the falling edge
	initial
	begin
		expRec e;
		forever
		begin
			@(negedge clk);
			if (bjQ.size() > 0 && bjQ[0].stamp == cycleNo - 1)
			begin
				e = bjQ.pop_front();
				checks++;
				assert (bjTaken === e.bjTaken && target === e.target)
				else
				begin
					errors++;
					$display("ERROR %0t: bjTaken %0b target %h, expected %0b %h", $time,
						bjTaken, target, e.bjTaken, e.target);
				end
			end
			if (wbQ.size() > 0 && wbQ[0].stamp == cycleNo - 2)
			begin
				e = wbQ.pop_front();
				checks++;
				assert (wbWe === e.we && wbRd === e.rd && excPending === e.excPending &&
					(!e.excPending || mCause === e.mCause))
				else
				begin
					errors++;
					$display("ERROR %0t: we %0b rd %0d exc %0b cause %h, expected %0b %0d %0b %h",
						$time, wbWe, wbRd, excPending, mCause, e.we, e.rd, e.excPending,
						e.mCause);
				end
				assert ((e.excPending || wbData === e.wbData) && csrWb === e.csrWb &&
					csrWbAddr === e.csrWbAddr)
				else
				begin
					errors++;
					$display("ERROR %0t: wbData %h csrWb %h @%h, expected %h %h @%h", $time,
						wbData, csrWb, csrWbAddr, e.wbData, e.csrWb, e.csrWbAddr);
				end
			end
		end
	end

	// four times the longest possible run
	initial
	begin
		#(maxIssues * period * 4);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/exeTop.sv ====
`default_nettype none

module exeTop #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic nrst,
	input logic [31:0] opA, opB, pc,
	input logic [31:0] bImm, jImm, uImm,
	input exePkg::aluOp aluOp,
	input exePkg::mulOp mulOp,
	input exePkg::csrOp csrOp,
	input logic [31:0] csrImm, csrData,
	input logic [11:0] csrAddr,
	input logic branch, branchNe, jump, jumpReg,
	input exePkg::wbSel wbSel,
	input logic [4:0] rd,
	input logic we, instrMisaligned, ecall,
	input exePkg::memOp memOp,
	input logic [31:0] memOffset,    // I or S immediate
	output logic bjTaken,
	output logic [31:0] target,
	output logic [31:0] wbData,
	output logic wbWe,
	output logic [4:0] wbRd,
	output logic [31:0] csrWb,
	output logic [11:0] csrWbAddr,
	output logic excPending,
	output logic [31:0] mCause
);

	logic [31:0] loadData;
	logic loadMisaligned;
	logic storeMisaligned;

	opBus opLink();
	resBus resLink();

	operandStage opStage (.out(opLink), .*);

	computeStage cmpStage (
		.clk(clk),
		.nrst(nrst),
		.in(opLink),
		.out(resLink),
		.bjTaken(bjTaken),
		.target(target)
	);

	// memory sees the issue directly, rs1 as base and rs2 as store data
	dataMem #(.memWords(memWords)) dmem (
		.clk(clk),
		.nrst(nrst),
		.op(memOp),
		.base(opA),
		.offset(memOffset),
		.storeData(opB),
		.loadData(loadData),
		.loadMisaligned(loadMisaligned),
		.storeMisaligned(storeMisaligned)
	);

	writebackStage wbStage (
		.in(resLink),
		.loadData(loadData),
		.loadMisaligned(loadMisaligned),
		.storeMisaligned(storeMisaligned),
		.wbData(wbData),
		.we(wbWe),
		.rd(wbRd),
		.csrWb(csrWb),
		.csrWbAddr(csrWbAddr),
		.excPending(excPending),
		.mCause(mCause)
	);

endmodule

`default_nettype wire

// ==== src/writebackStage.sv ====
`default_nettype none

module writebackStage (
	resBus.sink in,
	input logic [31:0] loadData,
	input logic loadMisaligned,
	input logic storeMisaligned,
	output logic [31:0] wbData,
	output logic we,
	output logic [4:0] rd,
	output logic [31:0] csrWb,
	output logic [11:0] csrWbAddr,
	output logic excPending,
	output logic [31:0] mCause
);

	logic [30:0] cause;

	always_comb
	begin
		case (in.wbSel)
			exePkg::wbAlu: wbData = in.aluRes;
			exePkg::wbPcLink: wbData = in.linkVal;
			exePkg::wbMulDiv: wbData = in.mulRes;
			exePkg::wbLui: wbData = in.luiVal;
			exePkg::wbLoad: wbData = loadData;
			exePkg::wbAuipc: wbData = in.auipcVal;
			exePkg::wbCsr: wbData = in.csrOld;  // old CSR value to rd
			default: wbData = '0;
		endcase
	end

	assign excPending = in.instrMisaligned || in.ecall || loadMisaligned || storeMisaligned;

	// earlier stage faults win
	always_comb
	begin
		if (in.instrMisaligned)
			cause = exePkg::causeInstrMisaligned;
		else if (in.ecall)
			cause = exePkg::causeEcallM;
		else if (loadMisaligned)
			cause = exePkg::causeLoadMisaligned;
		else if (storeMisaligned)
			cause = exePkg::causeStoreMisaligned;
		else
			cause = '0;
	end

	assign mCause = {!excPending, cause};  // bit 31 low marks an exception
	assign we = in.we && !excPending;
	assign rd = in.rd;
	assign csrWb = in.csrNew;
	assign csrWbAddr = in.csrAddr;

endmodule

`default_nettype wire

// ==== src/dataMem.sv ====
`default_nettype none

module dataMem #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic nrst,
	input exePkg::memOp op,
	input logic [31:0] base,
	input logic [31:0] offset,
	input logic [31:0] storeData,
	output logic [31:0] loadData,
	output logic loadMisaligned,
	output logic storeMisaligned
);

	localparam int idxW = $clog2(memWords);

	logic [31:0] mem [memWords];
	logic [31:0] addr;
	logic [idxW-1:0] idx;
	logic isLoad, isStore, misaligned, wrEn;
	logic [3:0] be;
	logic [31:0] wdata;
	exePkg::memOp op5;
	logic [idxW-1:0] idx5;
	logic [1:0] off5;
	logic misLd5, misSt5;
	logic [31:0] word;
	logic [7:0] lByte;
	logic [15:0] lHalf;
	logic [31:0] ext;

	assign addr = base + offset;
	assign idx = idxW'(addr[31:2] % memWords);  // wraps over the array

	always_comb
	begin
		isLoad = op inside {exePkg::memLb, exePkg::memLh, exePkg::memLw, exePkg::memLbu,
			exePkg::memLhu};
		isStore = op inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
		misaligned = 1'b0;
		be = 4'b0000;
		wdata = storeData;
		case (op)
			exePkg::memLh, exePkg::memLhu: misaligned = addr[0];
			exePkg::memLw: misaligned = |addr[1:0];
			exePkg::memSb:
			begin
				be = 4'b0001 << addr[1:0];
				wdata = {4{storeData[7:0]}};  // byte replicated on every lane
			end
			exePkg::memSh:
			begin
				misaligned = addr[0];
				be = 4'b0011 << {addr[1], 1'b0};
				wdata = {2{storeData[15:0]}};
			end
			exePkg::memSw:
			begin
				misaligned = |addr[1:0];
				be = 4'b1111;
			end
			default: ;
		endcase
	end

	assign wrEn = isStore && !misaligned;

	// store lands on the issue edge
	always_ff @(posedge clk)
	begin
		if (nrst && wrEn)
		begin
			for (int i = 0; i < 4; i++)
				if (be[i])
					mem[idx][8*i +: 8] <= wdata[8*i +: 8];
		end
	end

	// read from the registered address
	assign word = mem[idx5];
	assign lByte = word[{off5, 3'b000} +: 8];
	assign lHalf = off5[1] ? word[31:16] : word[15:0];

	always_comb
	begin
		case (op5)
			exePkg::memLb: ext = {{24{lByte[7]}}, lByte};
			exePkg::memLbu: ext = {24'b0, lByte};
			exePkg::memLh: ext = {{16{lHalf[15]}}, lHalf};
			exePkg::memLhu: ext = {16'b0, lHalf};
			default: ext = word;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			op5 <= exePkg::memNone;
			idx5 <= '0;
			off5 <= '0;
			misLd5 <= 1'b0;
			misSt5 <= 1'b0;
			loadData <= '0;
			loadMisaligned <= 1'b0;
			storeMisaligned <= 1'b0;
		end
		else
		begin
			op5 <= op;
			idx5 <= idx;
			off5 <= addr[1:0];
			misLd5 <= isLoad && misaligned;
			misSt5 <= isStore && misaligned;
			loadData <= ext;  // lines up with stage 6
			loadMisaligned <= misLd5;
			storeMisaligned <= misSt5;
		end
	end

	// a misaligned store leaves its word untouched
	noMisalignedWrite: assert property (@(posedge clk) disable iff (!nrst)
		isStore && misaligned |=> mem[$past(idx)] === $past(mem[idx]));

endmodule

`default_nettype wire

// ==== src/computeStage.sv ====
`default_nettype none

module computeStage (
	input logic clk,
	input logic nrst,
	opBus.sink in,
	resBus.src out,
	output logic bjTaken,
	output logic [31:0] target
);

	logic [31:0] aluRes;
	logic [31:0] mulRes;
	logic aluTaken;
	logic [31:0] csrSrc;
	logic [31:0] nextCsr;

	alu aluU (
		.op(in.alu),
		.a(in.opA),
		.b(in.opB),
		.branchNe(in.branchNe),
		.result(aluRes),
		.taken(aluTaken)
	);

	mulDiv mdU (
		.op(in.mul),
		.a(in.opA),
		.b(in.opB),
		.result(mulRes)
	);

	// jalr clears bit 0 of rs1 + imm
	always_comb
	begin
		if (in.jumpReg)
			target = (in.opA + in.opB) & ~32'd1;
		else if (in.jump)
			target = in.pc + in.jImm;
		else
			target = in.pc + in.bImm;
	end

	assign bjTaken = in.jump || in.jumpReg || (in.branch && aluTaken);

	// immediate forms take csrImm instead of rs1
	assign csrSrc = (in.csr inside {exePkg::csrRwi, exePkg::csrRsi, exePkg::csrRci}) ?
		in.csrImm : in.opA;

	always_comb
	begin
		case (in.csr)
			exePkg::csrRw, exePkg::csrRwi: nextCsr = csrSrc;
			exePkg::csrRs, exePkg::csrRsi: nextCsr = in.csrData | csrSrc;
			exePkg::csrRc, exePkg::csrRci: nextCsr = in.csrData & ~csrSrc;
			default: nextCsr = in.csrData;  // no CSR op, value unchanged
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			out.wbSel <= exePkg::wbAlu;
			out.rd <= '0;
			out.we <= 1'b0;
			out.instrMisaligned <= 1'b0;
			out.ecall <= 1'b0;
		end
		else
		begin
			out.wbSel <= in.wbSel;
			out.rd <= in.rd;
			out.we <= in.we;
			out.instrMisaligned <= in.instrMisaligned;
			out.ecall <= in.ecall;
		end
	end

	always_ff @(posedge clk)
	begin
		out.aluRes <= aluRes;
		out.mulRes <= mulRes;
		out.luiVal <= in.uImm;
		out.auipcVal <= in.pc + in.uImm;
		out.linkVal <= in.pc + 32'd4;
		out.csrOld <= in.csrData;
		out.csrNew <= nextCsr;
		out.csrAddr <= in.csrAddr;
	end

endmodule

`default_nettype wire

// ==== src/operandStage.sv ====
`default_nettype none

module operandStage (
	input logic clk,
	input logic nrst,
	input logic [31:0] opA, opB, pc,
	input logic [31:0] bImm, jImm, uImm,
	input exePkg::aluOp aluOp,
	input exePkg::mulOp mulOp,
	input exePkg::csrOp csrOp,
	input logic [31:0] csrImm, csrData,
	input logic [11:0] csrAddr,
	input logic branch, branchNe, jump, jumpReg,
	input exePkg::wbSel wbSel,
	input logic [4:0] rd,
	input logic we, instrMisaligned, ecall,
	opBus.src out
);

	// control fields
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			out.alu <= exePkg::aluAdd;
			out.mul <= exePkg::mdMul;
			out.csr <= exePkg::csrNone;
			out.branch <= 1'b0;
			out.branchNe <= 1'b0;
			out.jump <= 1'b0;
			out.jumpReg <= 1'b0;
			out.wbSel <= exePkg::wbAlu;
			out.rd <= '0;
			out.we <= 1'b0;
			out.instrMisaligned <= 1'b0;
			out.ecall <= 1'b0;
		end
		else
		begin
			out.alu <= aluOp;
			out.mul <= mulOp;
			out.csr <= csrOp;
			out.branch <= branch;
			out.branchNe <= branchNe;
			out.jump <= jump;
			out.jumpReg <= jumpReg;
			out.wbSel <= wbSel;
			out.rd <= rd;
			out.we <= we;
			out.instrMisaligned <= instrMisaligned;
			out.ecall <= ecall;
		end
	end

	// operands and immediates
	always_ff @(posedge clk)
	begin
		out.opA <= opA;
		out.opB <= opB;
		out.pc <= pc;
		out.bImm <= bImm;
		out.jImm <= jImm;
		out.uImm <= uImm;
		out.csrImm <= csrImm;
		out.csrData <= csrData;
		out.csrAddr <= csrAddr;
	end

	// decode never asks for a write from the unused selector
	weSelLegal: assert property (@(posedge clk) disable iff (!nrst)
		out.we |-> out.wbSel inside {[exePkg::wbAlu : exePkg::wbCsr]});

endmodule

`default_nettype wire

// ==== src/mulDiv.sv ====
`default_nettype none

module mulDiv (
	input exePkg::mulOp op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result
);

	logic [63:0] prodSs;
	logic [63:0] prodSu;
	logic [63:0] prodUu;
	logic [31:0] quotS;
	logic [31:0] remS;
	logic [31:0] quotU;
	logic [31:0] remU;
	logic divZero;
	logic overflow;

	// extended operands, product modulo 2^64 is exact
	assign prodSs = {{32{a[31]}}, a} * {{32{b[31]}}, b};
	assign prodSu = {{32{a[31]}}, a} * {32'b0, b};
	assign prodUu = {32'b0, a} * {32'b0, b};

	assign divZero = (b == 32'd0);
	assign overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);  // -2^31 / -1

	assign quotS = $signed(a) / $signed(b);
	assign remS = $signed(a) % $signed(b);
	assign quotU = a / b;
	assign remU = a % b;

	always_comb
	begin
		case (op)
			exePkg::mdMul: result = prodSs[31:0];
			exePkg::mdMulh: result = prodSs[63:32];
			exePkg::mdMulhsu: result = prodSu[63:32];
			exePkg::mdMulhu: result = prodUu[63:32];
			exePkg::mdDiv: result = divZero ? '1 : (overflow ? a : quotS);
			exePkg::mdDivu: result = divZero ? '1 : quotU;
			exePkg::mdRem: result = divZero ? a : (overflow ? '0 : remS);
			exePkg::mdRemu: result = divZero ? a : remU;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none

module alu (
	input exePkg::aluOp op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic branchNe,
	output logic [31:0] result,
	output logic taken
);

	logic cond;

	always_comb
	begin
		case (op)
			exePkg::aluAdd: result = a + b;
			exePkg::aluSub: result = a - b;
			exePkg::aluSll: result = a << b[4:0];
			exePkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			exePkg::aluSltu: result = {31'b0, a < b};
			exePkg::aluXor: result = a ^ b;
			exePkg::aluSrl: result = a >> b[4:0];
			exePkg::aluSra: result = $signed(a) >>> b[4:0];
			exePkg::aluOr: result = a | b;
			exePkg::aluAnd: result = a & b;
			default: result = '0;
		endcase
	end

	// branch compare type follows the ALU op
	always_comb
	begin
		case (op)
			exePkg::aluSub: cond = (a == b);                   // beq
			exePkg::aluSlt: cond = ($signed(a) < $signed(b));  // blt
			exePkg::aluSltu: cond = (a < b);                   // bltu
			default: cond = 1'b0;
		endcase
	end

	// bne, bge, bgeu are the inverted forms
	assign taken = cond ^ branchNe;

endmodule

`default_nettype wire

// ==== src/exeBus.sv ====
`default_nettype none

// stage 5 contents, operand register to compute logic
interface opBus;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] pc;
	logic [31:0] bImm;
	logic [31:0] jImm;
	logic [31:0] uImm;
	exePkg::aluOp alu;
	exePkg::mulOp mul;
	exePkg::csrOp csr;
	logic [31:0] csrImm;
	logic [31:0] csrData;
	logic [11:0] csrAddr;
	logic branch;
	logic branchNe;
	logic jump;
	logic jumpReg;
	exePkg::wbSel wbSel;
	logic [4:0] rd;
	logic we;
	logic instrMisaligned;
	logic ecall;

	modport src (output opA, opB, pc, bImm, jImm, uImm, alu, mul, csr, csrImm, csrData,
		csrAddr, branch, branchNe, jump, jumpReg, wbSel, rd, we, instrMisaligned, ecall);
	modport sink (input opA, opB, pc, bImm, jImm, uImm, alu, mul, csr, csrImm, csrData,
		csrAddr, branch, branchNe, jump, jumpReg, wbSel, rd, we, instrMisaligned, ecall);
endinterface

// stage 6 results, ready for the writeback mux
interface resBus;
	logic [31:0] aluRes;
	logic [31:0] mulRes;
	logic [31:0] luiVal;
	logic [31:0] auipcVal;
	logic [31:0] linkVal;
	logic [31:0] csrOld;  // goes to rd
	logic [31:0] csrNew;  // goes back to the CSR file
	logic [11:0] csrAddr;
	exePkg::wbSel wbSel;
	logic [4:0] rd;
	logic we;
	logic instrMisaligned;
	logic ecall;

	modport src (output aluRes, mulRes, luiVal, auipcVal, linkVal, csrOld, csrNew, csrAddr,
		wbSel, rd, we, instrMisaligned, ecall);
	modport sink (input aluRes, mulRes, luiVal, auipcVal, linkVal, csrOld, csrNew, csrAddr,
		wbSel, rd, we, instrMisaligned, ecall);
endinterface

`default_nettype wire

// ==== src/exePkg.sv ====
`default_nettype none

package exePkg;

	// ALU function, also picks the branch compare
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,  // beq/bne compare
		aluSll,
		aluSlt,  // blt/bge compare
		aluSltu, // bltu/bgeu compare
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOp;

	// writeback source, value 7 is unused
	typedef enum logic [2:0] {
		wbAlu,
		wbPcLink,
		wbMulDiv,
		wbLui,
		wbLoad,
		wbAuipc,
		wbCsr
	} wbSel;

	typedef enum logic [3:0] {
		memNone,
		memLb,
		memLh,
		memLw,
		memLbu,
		memLhu,
		memSb,
		memSh,
		memSw
	} memOp;

	// RV32M funct3 order
	typedef enum logic [2:0] {
		mdMul,
		mdMulh,
		mdMulhsu,
		mdMulhu,
		mdDiv,
		mdDivu,
		mdRem,
		mdRemu
	} mulOp;

	typedef enum logic [2:0] {
		csrNone,
		csrRw,
		csrRs,
		csrRc,
		csrRwi,
		csrRsi,
		csrRci
	} csrOp;

	// machine mode cause codes
	localparam logic [30:0] causeInstrMisaligned = 31'd0;
	localparam logic [30:0] causeLoadMisaligned = 31'd4;
	localparam logic [30:0] causeStoreMisaligned = 31'd6;
	localparam logic [30:0] causeEcallM = 31'd11;

endpackage

`default_nettype wire
